//--- proc_pkg.sv
// widths, opcodes and csr numbers of the pipeline
// enums for decode kind, alu function, branch type and mux selects
package proc_pkg;

  // data and instruction width
  localparam int XLEN        = 32;
  localparam int REG_ADDR_W  = 5;
  // instruction memory geometry, word addressed
  localparam int IMEM_WORDS  = 64;
  localparam int IMEM_ADDR_W = 6;

  // manager message registers
  localparam logic [11:0] CSR_PROC2MNGR = 12'h7C0;
  localparam logic [11:0] CSR_MNGR2PROC = 12'hFC0;

  // major opcodes of the kept subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [2:0] {
    KIND_NOP,
    KIND_RR,
    KIND_RI,
    KIND_BR,
    KIND_JAL,
    KIND_CSRR,
    KIND_CSRW,
    KIND_ILL
  } inst_kind_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_CP2
  } alu_fn_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE
  } br_type_e;

  // operand 2 source in D
  typedef enum logic [1:0] {OP2_RF, OP2_IMM, OP2_MNGR} op2_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_B, IMM_J} imm_type_e;
  // next fetch address
  typedef enum logic [1:0] {PC_PLUS4, PC_JAL, PC_BR} pc_sel_e;

endpackage

//--- proc_ctrl_if.sv
// control and status bundle between pipeline control and datapath
`timescale 1ns/1ps

interface proc_ctrl_if;

  // stage register enables
  logic reg_en_f;
  logic reg_en_d;
  logic reg_en_x;
  logic reg_en_m;
  logic reg_en_w;

  // mux selects and alu function
  proc_pkg::pc_sel_e   pc_sel;
  proc_pkg::imm_type_e imm_type;
  proc_pkg::op2_sel_e  op2_sel;
  proc_pkg::alu_fn_e   alu_fn_x;

  // register file write from W
  logic                            rf_wen_w;
  logic [proc_pkg::REG_ADDR_W-1:0] rf_waddr_w;

  // status back to control
  logic [proc_pkg::XLEN-1:0] inst_d;
  logic                      br_cond_eq_x;
  logic                      br_cond_lt_x;

  modport ctrl (
    output reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w,
    output pc_sel, imm_type, op2_sel, alu_fn_x, rf_wen_w, rf_waddr_w,
    input  inst_d, br_cond_eq_x, br_cond_lt_x
  );

  modport dpath (
    input  reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w,
    input  pc_sel, imm_type, op2_sel, alu_fn_x, rf_wen_w, rf_waddr_w,
    output inst_d, br_cond_eq_x, br_cond_lt_x
  );

endinterface

//--- proc_ctrl.sv
// pipeline control with decode, per-stage valid/stall/squash,
// raw hazard stalls and manager port handshakes
`timescale 1ns/1ps

module proc_ctrl (
  input  logic       clk,
  input  logic       reset,
  proc_ctrl_if.ctrl  ctrl,
  input  logic       mngr2proc_val_i,
  output logic       mngr2proc_rdy_o,
  input  logic       proc2mngr_rdy_i,
  output logic       proc2mngr_val_o
);

  logic val_f;
  logic val_d;
  logic val_x;
  logic val_m;
  logic val_w;

  // stalls originating in a stage and their spread versions
  logic ostall_d;
  logic ostall_w;
  logic stall_f;
  logic stall_d;
  logic stall_x;
  logic stall_m;
  logic stall_w;
  logic osquash_d;
  logic osquash_x;
  logic squash_f;
  logic squash_d;

  // ------------------------------------------------------------------------
  // F stage
  // ------------------------------------------------------------------------

  // fetch stays valid from the first edge out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else begin
      val_f <= 1'b1;
    end
  end

  assign stall_f  = val_f && (ostall_d || ostall_w);
  assign squash_f = val_f && (osquash_d || osquash_x);
  // pc holds at 0 until F turns valid
  assign ctrl.reg_en_f = val_f && (!stall_f || squash_f);

  // taken branch in X wins over jal in D
  always_comb begin
    if (osquash_x) begin
      ctrl.pc_sel = proc_pkg::PC_BR;
    end else if (osquash_d) begin
      ctrl.pc_sel = proc_pkg::PC_JAL;
    end else begin
      ctrl.pc_sel = proc_pkg::PC_PLUS4;
    end
  end

  // ------------------------------------------------------------------------
  // D stage
  // ------------------------------------------------------------------------

  assign ctrl.reg_en_d = !stall_d || squash_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (ctrl.reg_en_d) begin
      val_d <= val_f && !stall_f && !squash_f;
    end
  end

  logic [6:0]                      opcode_d;
  logic [2:0]                      funct3_d;
  logic [6:0]                      funct7_d;
  logic [11:0]                     csr_d;
  logic [proc_pkg::REG_ADDR_W-1:0] rs1_d;
  logic [proc_pkg::REG_ADDR_W-1:0] rs2_d;
  logic [proc_pkg::REG_ADDR_W-1:0] rd_d;

  assign opcode_d = ctrl.inst_d[6:0];
  assign rd_d     = ctrl.inst_d[11:7];
  assign funct3_d = ctrl.inst_d[14:12];
  assign rs1_d    = ctrl.inst_d[19:15];
  assign rs2_d    = ctrl.inst_d[24:20];
  assign funct7_d = ctrl.inst_d[31:25];
  assign csr_d    = ctrl.inst_d[31:20];

  proc_pkg::inst_kind_e kind_d;
  proc_pkg::alu_fn_e    alu_fn_d;
  proc_pkg::br_type_e   br_type_d;

  // instruction word to kind, alu function and branch type
  always_comb begin
    kind_d    = proc_pkg::KIND_ILL;
    alu_fn_d  = proc_pkg::ALU_ADD;
    br_type_d = proc_pkg::BR_NONE;
    case (opcode_d)
      proc_pkg::OPC_OP: begin
        kind_d = proc_pkg::KIND_RR;
        case ({funct7_d, funct3_d})
          {7'b0000000, 3'b000}: alu_fn_d = proc_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: alu_fn_d = proc_pkg::ALU_SUB;
          {7'b0000000, 3'b111}: alu_fn_d = proc_pkg::ALU_AND;
          {7'b0000000, 3'b110}: alu_fn_d = proc_pkg::ALU_OR;
          {7'b0000000, 3'b100}: alu_fn_d = proc_pkg::ALU_XOR;
          {7'b0000000, 3'b010}: alu_fn_d = proc_pkg::ALU_SLT;
          default:              kind_d   = proc_pkg::KIND_ILL;
        endcase
      end
      proc_pkg::OPC_OP_IMM: begin
        // canonical nop is addi x0, x0, 0
        kind_d = (ctrl.inst_d == 32'h0000_0013) ? proc_pkg::KIND_NOP : proc_pkg::KIND_RI;
        case (funct3_d)
          3'b000:  alu_fn_d = proc_pkg::ALU_ADD;
          3'b111:  alu_fn_d = proc_pkg::ALU_AND;
          3'b110:  alu_fn_d = proc_pkg::ALU_OR;
          3'b100:  alu_fn_d = proc_pkg::ALU_XOR;
          default: kind_d   = proc_pkg::KIND_ILL;
        endcase
      end
      proc_pkg::OPC_BRANCH: begin
        kind_d = proc_pkg::KIND_BR;
        case (funct3_d)
          3'b000:  br_type_d = proc_pkg::BR_BEQ;
          3'b001:  br_type_d = proc_pkg::BR_BNE;
          3'b100:  br_type_d = proc_pkg::BR_BLT;
          3'b101:  br_type_d = proc_pkg::BR_BGE;
          default: kind_d    = proc_pkg::KIND_ILL;
        endcase
      end
      proc_pkg::OPC_JAL: begin
        kind_d   = proc_pkg::KIND_JAL;
        alu_fn_d = proc_pkg::ALU_CP2;
      end
      proc_pkg::OPC_SYSTEM: begin
        alu_fn_d = proc_pkg::ALU_CP2;
        // csrr is csrrs rd, csr, x0 and csrw is csrrw x0, csr, rs1
        if (funct3_d == 3'b010 && rs1_d == '0 && csr_d == proc_pkg::CSR_MNGR2PROC) begin
          kind_d = proc_pkg::KIND_CSRR;
        end else if (funct3_d == 3'b001 && rd_d == '0 && csr_d == proc_pkg::CSR_PROC2MNGR) begin
          kind_d = proc_pkg::KIND_CSRW;
        end
      end
      default: ;
    endcase
  end

  logic rf_wen_d;
  logic rs1_en_d;
  logic rs2_en_d;

  // per-kind control set where illegal behaves like nop
  always_comb begin
    rf_wen_d      = 1'b0;
    rs1_en_d      = 1'b0;
    rs2_en_d      = 1'b0;
    ctrl.op2_sel  = proc_pkg::OP2_RF;
    ctrl.imm_type = proc_pkg::IMM_I;
    case (kind_d)
      proc_pkg::KIND_RR: begin
        rf_wen_d = 1'b1;
        rs1_en_d = 1'b1;
        rs2_en_d = 1'b1;
      end
      proc_pkg::KIND_RI: begin
        rf_wen_d     = 1'b1;
        rs1_en_d     = 1'b1;
        ctrl.op2_sel = proc_pkg::OP2_IMM;
      end
      proc_pkg::KIND_BR: begin
        rs1_en_d      = 1'b1;
        rs2_en_d      = 1'b1;
        ctrl.imm_type = proc_pkg::IMM_B;
      end
      proc_pkg::KIND_JAL: begin
        rf_wen_d      = 1'b1;
        ctrl.op2_sel  = proc_pkg::OP2_IMM;
        ctrl.imm_type = proc_pkg::IMM_J;
      end
      proc_pkg::KIND_CSRR: begin
        rf_wen_d     = 1'b1;
        ctrl.op2_sel = proc_pkg::OP2_MNGR;
      end
      proc_pkg::KIND_CSRW: rs1_en_d = 1'b1;
      default: ;
    endcase
  end

  logic                            rf_wen_x;
  logic                            rf_wen_m;
  logic                            rf_wen_pend_w;
  logic [proc_pkg::REG_ADDR_W-1:0] rf_waddr_x;
  logic [proc_pkg::REG_ADDR_W-1:0] rf_waddr_m;
  logic [proc_pkg::REG_ADDR_W-1:0] rf_waddr_w;

  // raw hit of a later-stage writer against the D sources
  function automatic logic raw_hit(input logic v, input logic wen,
                                   input logic [proc_pkg::REG_ADDR_W-1:0] waddr);
    raw_hit = v && wen && (waddr != '0)
              && ((rs1_en_d && waddr == rs1_d) || (rs2_en_d && waddr == rs2_d));
  endfunction

  logic hazard_d;
  logic mngr_wait_d;

  // no bypass so D waits until the writer has left W
  assign hazard_d = raw_hit(val_x, rf_wen_x, rf_waddr_x)
                 || raw_hit(val_m, rf_wen_m, rf_waddr_m)
                 || raw_hit(val_w, rf_wen_pend_w, rf_waddr_w);
  assign mngr_wait_d = (kind_d == proc_pkg::KIND_CSRR) && !mngr2proc_val_i;

  assign ostall_d  = val_d && (hazard_d || mngr_wait_d);
  assign stall_d   = val_d && (ostall_d || ostall_w);
  assign squash_d  = val_d && osquash_x;
  assign osquash_d = val_d && (kind_d == proc_pkg::KIND_JAL) && !stall_d;

  assign mngr2proc_rdy_o = val_d && (kind_d == proc_pkg::KIND_CSRR) && !stall_d && !squash_d;

  // ------------------------------------------------------------------------
  // X stage
  // ------------------------------------------------------------------------

  proc_pkg::br_type_e br_type_x;
  proc_pkg::alu_fn_e  alu_fn_x;
  logic               p2m_x;
  logic               br_taken_x;

  assign ctrl.reg_en_x = !stall_x;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
    end else if (ctrl.reg_en_x) begin
      val_x      <= val_d && !stall_d && !squash_d;
      rf_wen_x   <= rf_wen_d;
      rf_waddr_x <= rd_d;
      br_type_x  <= br_type_d;
      alu_fn_x   <= alu_fn_d;
      p2m_x      <= (kind_d == proc_pkg::KIND_CSRW);
    end
  end

  assign ctrl.alu_fn_x = alu_fn_x;

  always_comb begin
    case (br_type_x)
      proc_pkg::BR_BEQ: br_taken_x = ctrl.br_cond_eq_x;
      proc_pkg::BR_BNE: br_taken_x = !ctrl.br_cond_eq_x;
      proc_pkg::BR_BLT: br_taken_x = ctrl.br_cond_lt_x;
      proc_pkg::BR_BGE: br_taken_x = !ctrl.br_cond_lt_x;
      default:          br_taken_x = 1'b0;
    endcase
  end

  assign stall_x   = val_x && ostall_w;
  // a stalled branch must not redirect twice
  assign osquash_x = val_x && !stall_x && br_taken_x;

  // ------------------------------------------------------------------------
  // M and W stages
  // ------------------------------------------------------------------------

  logic p2m_m;
  logic p2m_w;

  assign stall_m       = val_m && ostall_w;
  assign ctrl.reg_en_m = !stall_m;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_m <= 1'b0;
    end else if (ctrl.reg_en_m) begin
      val_m      <= val_x && !stall_x;
      rf_wen_m   <= rf_wen_x;
      rf_waddr_m <= rf_waddr_x;
      p2m_m      <= p2m_x;
    end
  end

  // W only waits on the manager
  assign ostall_w      = val_w && p2m_w && !proc2mngr_rdy_i;
  assign stall_w       = ostall_w;
  assign ctrl.reg_en_w = !stall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (ctrl.reg_en_w) begin
      val_w         <= val_m && !stall_m;
      rf_wen_pend_w <= rf_wen_m;
      rf_waddr_w    <= rf_waddr_m;
      p2m_w         <= p2m_m;
    end
  end

  assign ctrl.rf_wen_w   = val_w && rf_wen_pend_w;
  assign ctrl.rf_waddr_w = rf_waddr_w;
  assign proc2mngr_val_o = val_w && p2m_w;

  // an offered word belongs to a valid csrw that just left M or waited in W
  a_p2m_from_w: assert property (@(posedge clk) disable iff (reset)
    proc2mngr_val_o |-> $past(val_m && p2m_m)
                        || $past(proc2mngr_val_o && !proc2mngr_rdy_i));

  // a redirect lets the branch leave X and squashes what follows it
  a_br_not_stalled: assert property (@(posedge clk) disable iff (reset)
    ctrl.pc_sel == proc_pkg::PC_BR |=> !val_x);

endmodule

//--- proc_imem.sv
// instruction memory, loaded through a write port, combinational read
`timescale 1ns/1ps

module proc_imem (
  input  logic                             clk,
  input  logic                             wen_i,
  input  logic [proc_pkg::IMEM_ADDR_W-1:0] waddr_i,
  input  logic [proc_pkg::XLEN-1:0]        wdata_i,
  input  logic [proc_pkg::IMEM_ADDR_W-1:0] raddr_i,
  output logic [proc_pkg::XLEN-1:0]        rdata_o
);

  logic [proc_pkg::XLEN-1:0] mem [proc_pkg::IMEM_WORDS];

  // one word per cycle while loading
  always_ff @(posedge clk) begin
    if (wen_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  assign rdata_o = mem[raddr_i];

endmodule

//--- proc_regfile.sv
// 32-entry register file, two read ports, one write port
`timescale 1ns/1ps

module proc_regfile (
  input  logic                            clk,
  input  logic [proc_pkg::REG_ADDR_W-1:0] raddr0_i,
  input  logic [proc_pkg::REG_ADDR_W-1:0] raddr1_i,
  output logic [proc_pkg::XLEN-1:0]       rdata0_o,
  output logic [proc_pkg::XLEN-1:0]       rdata1_o,
  input  logic                            wen_i,
  input  logic [proc_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [proc_pkg::XLEN-1:0]       wdata_i
);

  logic [proc_pkg::XLEN-1:0] regs [32];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wen_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // reads are combinational, x0 forced to zero
  assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];

endmodule

//--- proc_alu.sv
// alu with signed compare outputs for branches
`timescale 1ns/1ps

module proc_alu (
  input  proc_pkg::alu_fn_e         fn_i,
  input  logic [proc_pkg::XLEN-1:0] op1_i,
  input  logic [proc_pkg::XLEN-1:0] op2_i,
  output logic [proc_pkg::XLEN-1:0] result_o,
  output logic                      eq_o,
  output logic                      lt_o
);

  // compares shared by slt and the branch conditions
  assign eq_o = (op1_i == op2_i);
  assign lt_o = ($signed(op1_i) < $signed(op2_i));

  always_comb begin
    case (fn_i)
      proc_pkg::ALU_ADD: result_o = op1_i + op2_i;
      proc_pkg::ALU_SUB: result_o = op1_i - op2_i;
      proc_pkg::ALU_AND: result_o = op1_i & op2_i;
      proc_pkg::ALU_OR:  result_o = op1_i | op2_i;
      proc_pkg::ALU_XOR: result_o = op1_i ^ op2_i;
      proc_pkg::ALU_SLT: result_o = {{(proc_pkg::XLEN-1){1'b0}}, lt_o};
      // csrr and jal pass operand 2 through
      proc_pkg::ALU_CP2: result_o = op2_i;
      default:           result_o = '0;
    endcase
  end

endmodule

//--- proc_dpath.sv
// datapath: pc, stage data registers, immediates, operand muxes,
// instruction memory, register file and alu
`timescale 1ns/1ps

module proc_dpath (
  input  logic                             clk,
  input  logic                             reset,
  proc_ctrl_if.dpath                       dpath,
  input  logic                             imem_wen_i,
  input  logic [proc_pkg::IMEM_ADDR_W-1:0] imem_waddr_i,
  input  logic [proc_pkg::XLEN-1:0]        imem_wdata_i,
  input  logic [proc_pkg::XLEN-1:0]        mngr2proc_msg_i,
  output logic [proc_pkg::XLEN-1:0]        proc2mngr_msg_o
);

  logic [proc_pkg::XLEN-1:0] pc_f;
  logic [proc_pkg::XLEN-1:0] pc_next_f;
  logic [proc_pkg::XLEN-1:0] inst_f;
  logic [proc_pkg::XLEN-1:0] pc_d;
  logic [proc_pkg::XLEN-1:0] inst_d;
  logic [proc_pkg::XLEN-1:0] imm_d;
  logic [proc_pkg::XLEN-1:0] targ_d;
  logic [proc_pkg::XLEN-1:0] rs1_data_d;
  logic [proc_pkg::XLEN-1:0] rs2_data_d;
  logic [proc_pkg::XLEN-1:0] op2_d;
  logic [proc_pkg::XLEN-1:0] op1_x;
  logic [proc_pkg::XLEN-1:0] op2_x;
  logic [proc_pkg::XLEN-1:0] br_targ_x;
  logic [proc_pkg::XLEN-1:0] alu_result_x;
  logic [proc_pkg::XLEN-1:0] result_m;
  logic [proc_pkg::XLEN-1:0] opnd_m;
  logic [proc_pkg::XLEN-1:0] result_w;
  logic [proc_pkg::XLEN-1:0] opnd_w;

  // ------------------------------------------------------------------------
  // fetch
  // ------------------------------------------------------------------------

  always_comb begin
    case (dpath.pc_sel)
      proc_pkg::PC_JAL: pc_next_f = targ_d;
      proc_pkg::PC_BR:  pc_next_f = br_targ_x;
      default:          pc_next_f = pc_f + 32'd4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= '0;
    end else if (dpath.reg_en_f) begin
      pc_f <= pc_next_f;
    end
  end

  proc_imem u_imem (
    .clk     (clk),
    .wen_i   (imem_wen_i),
    .waddr_i (imem_waddr_i),
    .wdata_i (imem_wdata_i),
    .raddr_i (pc_f[proc_pkg::IMEM_ADDR_W+1:2]),
    .rdata_o (inst_f)
  );

  // ------------------------------------------------------------------------
  // decode
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (dpath.reg_en_d) begin
      inst_d <= inst_f;
      pc_d   <= pc_f;
    end
  end

  assign dpath.inst_d = inst_d;

  always_comb begin
    case (dpath.imm_type)
      proc_pkg::IMM_B: imm_d = {{19{inst_d[31]}}, inst_d[31], inst_d[7],
                                inst_d[30:25], inst_d[11:8], 1'b0};
      proc_pkg::IMM_J: imm_d = {{11{inst_d[31]}}, inst_d[31], inst_d[19:12],
                                inst_d[20], inst_d[30:21], 1'b0};
      default:         imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  // one adder for jal and branch targets
  assign targ_d = pc_d + imm_d;

  proc_regfile u_regfile (
    .clk      (clk),
    .raddr0_i (inst_d[19:15]),
    .raddr1_i (inst_d[24:20]),
    .rdata0_o (rs1_data_d),
    .rdata1_o (rs2_data_d),
    .wen_i    (dpath.rf_wen_w),
    .waddr_i  (dpath.rf_waddr_w),
    .wdata_i  (result_w)
  );

  // jal sends its link address down the immediate path
  always_comb begin
    case (dpath.op2_sel)
      proc_pkg::OP2_IMM:  op2_d = (dpath.imm_type == proc_pkg::IMM_J) ? pc_d + 32'd4 : imm_d;
      proc_pkg::OP2_MNGR: op2_d = mngr2proc_msg_i;
      default:            op2_d = rs2_data_d;
    endcase
  end

  // ------------------------------------------------------------------------
  // execute, memory, writeback
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (dpath.reg_en_x) begin
      op1_x     <= rs1_data_d;
      op2_x     <= op2_d;
      br_targ_x <= targ_d;
    end
  end

  proc_alu u_alu (
    .fn_i     (dpath.alu_fn_x),
    .op1_i    (op1_x),
    .op2_i    (op2_x),
    .result_o (alu_result_x),
    .eq_o     (dpath.br_cond_eq_x),
    .lt_o     (dpath.br_cond_lt_x)
  );

  // M is a pass-through stage
  always_ff @(posedge clk) begin
    if (dpath.reg_en_m) begin
      result_m <= alu_result_x;
      opnd_m   <= op1_x;
    end
  end

  always_ff @(posedge clk) begin
    if (dpath.reg_en_w) begin
      result_w <= result_m;
      opnd_w   <= opnd_m;
    end
  end

  // csrw sends its rs1 operand
  assign proc2mngr_msg_o = opnd_w;

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc_f[1:0] == 2'b00);

endmodule

//--- proc_top.sv
// processor top level: control, datapath and the bundle between them
`timescale 1ns/1ps

module proc_top (
  input  logic                             clk,
  input  logic                             reset,
  // program load, used during reset
  input  logic                             imem_wen_i,
  input  logic [proc_pkg::IMEM_ADDR_W-1:0] imem_waddr_i,
  input  logic [proc_pkg::XLEN-1:0]        imem_wdata_i,
  // manager to processor
  input  logic                             mngr2proc_val_i,
  output logic                             mngr2proc_rdy_o,
  input  logic [proc_pkg::XLEN-1:0]        mngr2proc_msg_i,
  // processor to manager
  output logic                             proc2mngr_val_o,
  input  logic                             proc2mngr_rdy_i,
  output logic [proc_pkg::XLEN-1:0]        proc2mngr_msg_o
);

  proc_ctrl_if ctrl_bus ();

  proc_ctrl u_ctrl (
    .clk             (clk),
    .reset           (reset),
    .ctrl            (ctrl_bus.ctrl),
    .mngr2proc_val_i (mngr2proc_val_i),
    .mngr2proc_rdy_o (mngr2proc_rdy_o),
    .proc2mngr_rdy_i (proc2mngr_rdy_i),
    .proc2mngr_val_o (proc2mngr_val_o)
  );

  proc_dpath u_dpath (
    .clk             (clk),
    .reset           (reset),
    .dpath           (ctrl_bus.dpath),
    .imem_wen_i      (imem_wen_i),
    .imem_waddr_i    (imem_waddr_i),
    .imem_wdata_i    (imem_wdata_i),
    .mngr2proc_msg_i (mngr2proc_msg_i),
    .proc2mngr_msg_o (proc2mngr_msg_o)
  );

endmodule

//--- proc_tb.sv
// testbench for proc_top with trace reading, clock and reset, program load,
// random manager back-pressure, output checks and watchdog
`timescale 1ns/1ps

module proc_tb;

  logic                             clk;
  logic                             reset;
  logic                             imem_wen_i;
  logic [proc_pkg::IMEM_ADDR_W-1:0] imem_waddr_i;
  logic [proc_pkg::XLEN-1:0]        imem_wdata_i;
  logic                             mngr2proc_val_i;
  logic                             mngr2proc_rdy_o;
  logic [proc_pkg::XLEN-1:0]        mngr2proc_msg_i;
  logic                             proc2mngr_val_o;
  logic                             proc2mngr_rdy_i;
  logic [proc_pkg::XLEN-1:0]        proc2mngr_msg_o;

  // trace contents as program, source values and expected outputs
  logic [31:0] prog_q [$];
  logic [31:0] src_q  [$];
  logic [31:0] exp_q  [$];

  int          src_idx;
  int          out_idx;
  int          value_errs;
  int          proto_errs;
  int          cycles_after_reset;
  logic        trace_loaded;
  logic [31:0] rnd;

  proc_top uut (
    .clk             (clk),
    .reset           (reset),
    .imem_wen_i      (imem_wen_i),
    .imem_waddr_i    (imem_waddr_i),
    .imem_wdata_i    (imem_wdata_i),
    .mngr2proc_val_i (mngr2proc_val_i),
    .mngr2proc_rdy_o (mngr2proc_rdy_o),
    .mngr2proc_msg_i (mngr2proc_msg_i),
    .proc2mngr_val_o (proc2mngr_val_o),
    .proc2mngr_rdy_i (proc2mngr_rdy_i),
    .proc2mngr_msg_o (proc2mngr_msg_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // xorshift32 step
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ---------------------------------------------------------------------------
  // trace file
  // ---------------------------------------------------------------------------

  task automatic read_trace();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  tag;
    logic [31:0] val;
    fd = $fopen("proc_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open proc_trace.txt");
      proto_errs++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, " %c %h", tag, val);
      // blank and comment lines give fewer fields
      if (n == 2) begin
        case (tag)
          "I": prog_q.push_back(val);
          "S": src_q.push_back(val);
          "E": exp_q.push_back(val);
          default: ;
        endcase
      end
    end
    $fclose(fd);
  endtask

  // new random handshake inputs 1 ns after the edge
  task automatic drive_ports();
    rnd = xorshift(rnd);
    mngr2proc_val_i = (src_idx < src_q.size()) && (rnd[3:2] != 2'b00);
    mngr2proc_msg_i = (src_idx < src_q.size()) ? src_q[src_idx] : '0;
    proc2mngr_rdy_i = (rnd[9:8] != 2'b00);
  endtask

  // ---------------------------------------------------------------------------
  // monitor sampled mid-cycle
  // ---------------------------------------------------------------------------

  always @(negedge clk) begin
    // quiet ports in reset and in the first cycle after it
    if (reset || cycles_after_reset == 0) begin
      assert (proc2mngr_val_o === 1'b0 && mngr2proc_rdy_o === 1'b0) else begin
        $display("manager port active during reset or first cycle at %0t", $time);
        proto_errs++;
      end
    end
    if (mngr2proc_val_i === 1'b1 && mngr2proc_rdy_o === 1'b1) begin
      src_idx++;
    end
    if (proc2mngr_val_o === 1'b1 && proc2mngr_rdy_i === 1'b1) begin
      assert (out_idx < exp_q.size()) else begin
        $display("extra proc2mngr transfer of %h at %0t", proc2mngr_msg_o, $time);
        proto_errs++;
      end
      if (out_idx < exp_q.size()) begin
        assert (proc2mngr_msg_o === exp_q[out_idx]) else begin
          $display("FAIL %0t: output %0d is %h, expected %h", $time, out_idx,
                   proc2mngr_msg_o, exp_q[out_idx]);
          value_errs++;
        end
      end
      out_idx++;
    end
    if (!reset) begin
      cycles_after_reset++;
    end
  end

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------

  initial begin
    reset              = 1'b1;
    imem_wen_i         = 1'b0;
    imem_waddr_i       = '0;
    imem_wdata_i       = '0;
    mngr2proc_val_i    = 1'b0;
    mngr2proc_msg_i    = '0;
    proc2mngr_rdy_i    = 1'b0;
    src_idx            = 0;
    out_idx            = 0;
    value_errs         = 0;
    proto_errs         = 0;
    cycles_after_reset = 0;
    trace_loaded       = 1'b0;
    rnd                = 32'd5;
    read_trace();
    trace_loaded = 1'b1;
    assert (prog_q.size() <= 16 && exp_q.size() > 0) else begin
      $display("trace holds too many program words or no expected outputs");
      proto_errs++;
    end
    // edge k writes word k-1 and all 16 edges stay in reset
    for (int k = 0; k <= 16; k++) begin
      if (k > 0) begin
        @(posedge clk);
        #1;
      end
      imem_wen_i   = (k < prog_q.size()) && (k < 16);
      imem_waddr_i = k[proc_pkg::IMEM_ADDR_W-1:0];
      imem_wdata_i = (k < prog_q.size()) ? prog_q[k] : '0;
    end
    reset      = 1'b0;
    imem_wen_i = 1'b0;
    drive_ports();
    while (out_idx < exp_q.size()) begin
      @(posedge clk);
      #1;
      drive_ports();
    end
    // drain with nothing more allowed out
    repeat (40) begin
      @(posedge clk);
      #1;
      drive_ports();
    end
    assert (src_idx == src_q.size()) else begin
      $display("%0d of %0d manager inputs consumed", src_idx, src_q.size());
      proto_errs++;
    end
    $display("errors: value %0d, protocol %0d, outputs %0d of %0d",
             value_errs, proto_errs, out_idx, exp_q.size());
    if (value_errs == 0 && proto_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog sized from the trace
  initial begin
    wait (trace_loaded);
    repeat (16 + 200 * exp_q.size() + prog_q.size()) @(posedge clk);
    $display("timeout: %0d of %0d outputs seen", out_idx, exp_q.size());
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- proc_trace.txt
# tag value: I program word (pc order), S mngr2proc value, E expected proc2mngr value
# text after the value is ignored
#
# program
I FC0020F3  # 0x00 csrr x1, mngr2proc       x1 = 7
I FC002173  # 0x04 csrr x2, mngr2proc       x2 = -3
I 402081B3  # 0x08 sub  x3, x1, x2          x3 = 10
I 0131C213  # 0x0c xori x4, x3, 0x13        x4 = 0x19
I 7C021073  # 0x10 csrw proc2mngr, x4       out 0x19
I 001122B3  # 0x14 slt  x5, x2, x1          x5 = 1
I 00028463  # 0x18 beq  x5, x0, +8          not taken
I 00029463  # 0x1c bne  x5, x0, +8          taken to 0x24
I 7C009073  # 0x20 csrw proc2mngr, x1       skipped
I 00115463  # 0x24 bge  x2, x1, +8          not taken
I 00114463  # 0x28 blt  x2, x1, +8          taken to 0x30
I 7C011073  # 0x2c csrw proc2mngr, x2       skipped
I 0080036F  # 0x30 jal  x6, +8              x6 = 0x34, to 0x38
I 7C009073  # 0x34 csrw proc2mngr, x1       skipped
I 7C031073  # 0x38 csrw proc2mngr, x6       out 0x34
I 0000006F  # 0x3c jal  x0, 0               end loop
#
# manager inputs in read order
S 00000007
S FFFFFFFD
#
# expected outputs in program order
E 00000019
E 00000034

//--- proc_top.f
proc_pkg.sv
proc_ctrl_if.sv
proc_ctrl.sv
proc_imem.sv
proc_regfile.sv
proc_alu.sv
proc_dpath.sv
proc_top.sv
proc_tb.sv
